/* dbp_top.f */
logic/dbp_pkg.sv
logic/dbp_dp_regs.sv
logic/dbp_rom_table.sv
logic/dbp_cmd_router.sv
logic/dbp_apb_ap.sv
logic/dbp_top.sv
+incdir+verification
verification/dbp_tb.sv

/* verification/dbp_tb_model.svh */
// debug port reference model
`ifndef DBP_TB_MODEL_SVH
`define DBP_TB_MODEL_SVH

// model copies of the DP registers and the APB slave memory
logic [31:0] m_sel;
logic [31:0] m_addr;
logic [31:0] m_data;
logic [31:0] m_cmd;
logic [31:0] ref_mem [0:63];

// fill pattern, every word differs
function automatic logic [31:0] mem_fill(input int idx);
  return 32'hA5C3_0000 ^ (idx * 32'h0101_0111) ^ (idx << 20);
endfunction

// listed ROM words, everything else zero
function automatic logic [31:0] rom_lookup(input logic [11:0] off);
  case (off)
    12'h000: return 32'h0000_2003;
    12'h004: return 32'h0000_3003;
    12'h400: return 32'h10;
    12'hFD0: return 32'h04;
    12'hFE0: return 32'h01;
    12'hFE4: return 32'h80;
    12'hFE8: return 32'h0D;
    12'hFF0: return 32'h0D;
    12'hFF4: return 32'h10;
    12'hFF8: return 32'h05;
    12'hFFC: return 32'hB1;
    default: return 32'h0;
  endcase
endfunction

// DP register file, updates the model state on writes
function automatic dbp_pkg::dbg_rsp_t model_dp(input dbp_pkg::dbg_req_t req);
  logic [11:0]       off;
  logic              rd;
  logic              wr;
  logic              sel_off;
  logic              sel_ok;
  logic              rom;
  logic              mapped;
  logic              err;
  logic [31:0]       val;
  dbp_pkg::dbg_rsp_t r;
  off     = req.addr[11:0];
  rd      = (req.cmd == 2'd1);
  wr      = (req.cmd == 2'd2);
  sel_off = (off == 12'h020);
  sel_ok  = (m_sel[31:2] == 0) && (m_sel[1:0] <= 2'd1);
  rom     = (m_sel[1:0] == 2'd1);
  mapped  = 1'b1;
  val     = 32'h0;
  case (off)
    12'h000: val = 32'h24;
    12'h004: val = m_cmd;
    12'h008, 12'h018: val = m_addr;
    12'h00C, 12'h014: val = rom ? rom_lookup(m_addr[11:0]) : m_data;
    12'h010: val = 32'h0;
    12'h020: val = m_sel;
    12'h400: val = rom ? 32'h10 : 32'h0001_04B0;
    12'h404: val = 32'h0;
    12'h408: val = rom ? 32'h0 : 32'd32;
    12'h40C: val = rom ? 32'h0 : 32'h0000_1000;
    12'h410: val = 32'h0;
    default: mapped = 1'b0;
  endcase
  err = !mapped || !(rd || wr) || (req.be != 4'hF) || (rd && off == 12'h010) ||
        (!sel_off && !sel_ok) ||
        (wr && sel_off && (req.wdata[1:0] == 2'd3 || req.wdata[31:2] != 0));
  // bad select words are kept anyway
  if (wr && req.be == 4'hF && (sel_off || sel_ok))
  begin
    case (off)
      12'h020: m_sel  = req.wdata;
      12'h008: m_addr = req.wdata;
      12'h00C: m_data = req.wdata;
      12'h004: m_cmd  = req.wdata;
      default: ;
    endcase
  end
  r.err   = err;
  r.rdata = (rd && !err) ? val : 32'h0;
  return r;
endfunction

// APB access port against the slave memory
function automatic dbp_pkg::dbg_rsp_t model_apb(input dbp_pkg::dbg_req_t req, input logic stall);
  dbp_pkg::dbg_rsp_t r;
  r.err   = stall || req.addr[31];
  r.rdata = 32'h0;
  if (!r.err && req.cmd == 2'd1)
    r.rdata = ref_mem[req.addr[7:2]];
  if (!r.err && req.cmd == 2'd2)
    ref_mem[req.addr[7:2]] = req.wdata;
  return r;
endfunction

// select offset always goes to the DP, clean APB target to the AP
function automatic dbp_pkg::dbg_rsp_t model_cmd(input dbp_pkg::dbg_req_t req, input logic stall);
  if (req.addr[11:0] != 12'h020 && m_sel[31:2] == 0 && m_sel[1:0] == 2'd2)
    return model_apb(req, stall);
  return model_dp(req);
endfunction

`endif

/* verification/dbp_tb.sv */
// debug port testbench
`timescale 1ns/1ps

module dbp_tb;

  logic              clk;
  logic              rst_a_s;
  dbp_pkg::dbg_req_t i_dbg_req;
  logic              i_dbg_cmdval;
  logic              o_dbg_cmdack;
  dbp_pkg::dbg_rsp_t o_dbg_rsp;
  logic              o_dbg_rspval;
  logic              i_dbg_rspack;
  dbp_pkg::apb_req_t apb_out;
  dbp_pkg::apb_rsp_t i_apb;

  integer            seed = 19908;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  // slave model state
  logic              stall;
  logic [31:0]       slv_mem [0:63];
  int                wcnt;
  int                slv_wait;
  dbp_pkg::apb_req_t seen_apb;

  `include "dbp_tb_model.svh"

  dbp_top #(.APB_WAIT_LIMIT(16)) uut (
    .clk          (clk),
    .rst_a_s      (rst_a_s),
    .i_dbg_req    (i_dbg_req),
    .i_dbg_cmdval (i_dbg_cmdval),
    .o_dbg_cmdack (o_dbg_cmdack),
    .o_dbg_rsp    (o_dbg_rsp),
    .o_dbg_rspval (o_dbg_rspval),
    .i_dbg_rspack (i_dbg_rspack),
    .o_apb        (apb_out),
    .i_apb        (i_apb)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // APB slave with 0 to 3 wait states and pslverr on address bit 31

  always @(posedge clk)
  begin
    if (apb_out.psel && !apb_out.penable)
    begin
      seen_apb <= apb_out;
      slv_wait = $unsigned($random(seed)) % 4;
      wcnt <= slv_wait;
      if (slv_wait == 0 && !stall)
        present_ready();
    end
    else if (apb_out.psel && apb_out.penable)
    begin
      // write lands on the completing edge unless pslverr
      if (i_apb.pready)
      begin
        if (apb_out.pwrite && !i_apb.pslverr)
          slv_mem[apb_out.paddr[5:0]] <= apb_out.pwdata;
        i_apb <= '0;
      end
      else if (!stall)
      begin
        if (wcnt <= 1)
          present_ready();
        wcnt <= wcnt - 1;
      end
    end
    else
      i_apb <= '0;
  end

  task automatic present_ready();
    i_apb.pready  <= 1'b1;
    i_apb.pslverr <= apb_out.paddr[29];
    i_apb.prdata  <= apb_out.paddr[29] ? 32'h0 : slv_mem[apb_out.paddr[5:0]];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and command driver

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic check_rsp(input string name, input dbp_pkg::dbg_rsp_t exp,
                           input dbp_pkg::dbg_rsp_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
    end
  endtask

  task automatic check_apb(input string name, input dbp_pkg::apb_req_t exp,
                           input dbp_pkg::apb_req_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s expected apb=%h actual apb=%h", name, exp, act);
    end
  endtask

  // one command with latency counted from the accept edge
  task automatic run_cmd(input string name, input dbp_pkg::dbg_req_t req, input int ack_delay,
                         output dbp_pkg::dbg_rsp_t rsp, output int lat);
    int n;
    @(posedge clk);
    i_dbg_req    <= req;
    i_dbg_cmdval <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      if (n > 50)
        abort_run({"timeout waiting for command accept in ", name});
    end
    while (!o_dbg_cmdack);
    i_dbg_cmdval <= 1'b0;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      if (n > 100)
        abort_run({"timeout waiting for response in ", name});
    end
    while (!o_dbg_rspval);
    // seen one edge after it rose
    lat = n - 1;
    rsp = o_dbg_rsp;
    for (int i = 0; i < ack_delay; i++)
    begin
      @(posedge clk);
      if (!o_dbg_rspval || o_dbg_rsp !== rsp)
      begin
        errors++;
        $display("%s: response changed while rspack was held off", name);
      end
      if (o_dbg_cmdack)
      begin
        errors++;
        $display("%s: command port ready while a response was pending", name);
      end
    end
    i_dbg_rspack <= 1'b1;
    @(posedge clk);
    i_dbg_rspack <= 1'b0;
  endtask

  // drive, predict and compare
  task automatic issue(input string name, input logic [31:0] addr, input logic [1:0] cmd,
                       input logic [3:0] be, input logic [31:0] wdata, input int ack_delay);
    dbp_pkg::dbg_req_t req;
    dbp_pkg::dbg_rsp_t exp;
    dbp_pkg::dbg_rsp_t act;
    int                lat;
    req = '{addr: addr, be: be, cmd: cmd, wdata: wdata};
    exp = model_cmd(req, stall);
    run_cmd(name, req, ack_delay, act, lat);
    check_rsp(name, exp, act);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  logic [11:0] rd_offs [0:11] = '{12'h000, 12'h004, 12'h008, 12'h00C, 12'h014, 12'h018,
                                  12'h020, 12'h400, 12'h404, 12'h408, 12'h40C, 12'h410};
  logic [11:0] wr_offs [0:3]  = '{12'h008, 12'h00C, 12'h004, 12'h020};
  logic [11:0] rom_offs [0:10] = '{12'h000, 12'h004, 12'h400, 12'hFD0, 12'hFE0, 12'hFE4,
                                   12'hFE8, 12'hFF0, 12'hFF4, 12'hFF8, 12'hFFC};

  initial
  begin
    int                e0;
    int                lat;
    logic [11:0]       off;
    logic [31:0]       a;
    logic [31:0]       d;
    logic [1:0]        c;
    dbp_pkg::dbg_req_t req;
    dbp_pkg::dbg_rsp_t act;
    dbp_pkg::apb_req_t exp_apb;
    clk = 1'b0;
    rst_a_s = 1'b1;
    i_dbg_req = '0;
    i_dbg_cmdval = 1'b0;
    i_dbg_rspack = 1'b0;
    i_apb = '0;
    stall = 1'b0;
    wcnt = 0;
    m_sel = 0;
    m_addr = 0;
    m_data = 0;
    m_cmd = 0;
    for (int i = 0; i < 64; i++)
    begin
      slv_mem[i] = mem_fill(i);
      ref_mem[i] = mem_fill(i);
    end
    repeat (5) @(posedge clk);
    rst_a_s <= 1'b0;

    // reset values and DP latency
    e0 = errors;
    issue("reset_select", 32'h020, 2'd1, 4'hF, 0, 0);
    issue("reset_status", 32'h000, 2'd1, 4'hF, 0, 0);
    req = '{addr: 32'h008, be: 4'hF, cmd: 2'd1, wdata: 0};
    run_cmd("reset_addr", req, 0, act, lat);
    check_rsp("reset_addr", model_cmd(req, 1'b0), act);
    checks++;
    if (lat != 2)
    begin
      errors++;
      $display("[FAIL] reset_addr latency expected 2 actual %0d", lat);
    end
    end_test("reset", e0);

    // random register writes and reads
    e0 = errors;
    for (int i = 0; i < 40; i++)
    begin
      a = $random(seed);
      d = $random(seed);
      if (i % 2 == 0)
      begin
        off = wr_offs[$unsigned($random(seed)) % 4];
        if (off == 12'h020)
          d = 0;
        issue("regs_write", {a[31:12], off}, 2'd2, 4'hF, d, 0);
      end
      else
        issue("regs_read", {a[31:12], rd_offs[$unsigned($random(seed)) % 12]}, 2'd1, 4'hF, 0,
              $unsigned($random(seed)) % 6);
    end
    end_test("regs", e0);

    // error rules
    e0 = errors;
    issue("err_unmapped", 32'h030, 2'd1, 4'hF, 0, 0);
    issue("err_cmd0", 32'h008, 2'd0, 4'hF, 0, 0);
    issue("err_cmd3", 32'h008, 2'd3, 4'hF, 0, 0);
    issue("err_partial_be", 32'h00C, 2'd2, 4'h7, 32'h1234, 0);
    issue("err_read_reset", 32'h010, 2'd1, 4'hF, 0, 0);
    issue("err_sel_target3", 32'h020, 2'd2, 4'hF, 32'h3, 0);
    issue("err_after_bad_sel", 32'h000, 2'd1, 4'hF, 0, 0);
    issue("err_sel_upper", 32'h020, 2'd2, 4'hF, 32'h100, 0);
    issue("err_after_upper", 32'h008, 2'd2, 4'hF, 32'h55, 0);
    issue("sel_rewrite", 32'h020, 2'd2, 4'hF, 32'h0, 0);
    issue("status_again", 32'h000, 2'd1, 4'hF, 0, 0);
    end_test("errors", e0);

    // ROM table through the data register
    e0 = errors;
    issue("rom_select", 32'h020, 2'd2, 4'hF, 32'h1, 0);
    for (int i = 0; i < 24; i++)
    begin
      a = $random(seed);
      if (i % 2 == 0)
        a[11:0] = rom_offs[$unsigned($random(seed)) % 11];
      else
        a[1:0] = 2'b00;
      issue("rom_addr", 32'h008, 2'd2, 4'hF, a, 0);
      issue("rom_data", (i % 3 == 0) ? 32'h014 : 32'h00C, 2'd1, 4'hF, 0, 0);
    end
    issue("rom_csr1", 32'h400, 2'd1, 4'hF, 0, 0);
    end_test("rom", e0);

    // APB access port
    e0 = errors;
    issue("apb_select", 32'h020, 2'd2, 4'hF, 32'h2, 0);
    for (int i = 0; i < 30; i++)
    begin
      a = $random(seed);
      // offset kept off the select register
      a[11:8] = 4'h1;
      a[1:0] = 2'b00;
      a[31] = (($unsigned($random(seed)) % 4) == 0);
      d = $random(seed);
      c = ($random(seed) & 1) ? 2'd2 : 2'd1;
      issue("apb_xfer", a, c, 4'hF, d, $unsigned($random(seed)) % 6);
      exp_apb = '{paddr: a[31:2], psel: 1'b1, penable: 1'b0, pwrite: (c == 2'd2), pwdata: d};
      check_apb("apb_setup", exp_apb, seen_apb);
    end
    issue("apb_sel_read", 32'h020, 2'd1, 4'hF, 0, 0);
    end_test("apb", e0);

    // stalled slave times out and a held response follows
    e0 = errors;
    stall = 1'b1;
    issue("apb_stall", 32'h104, 2'd1, 4'hF, 0, 0);
    stall = 1'b0;
    issue("apb_backpressure", 32'h108, 2'd1, 4'hF, 0, 5);
    issue("apb_after_hold", 32'h10C, 2'd2, 4'hF, 32'hCAFE_0001, 3);
    end_test("timeout_backpressure", e0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* logic/dbp_top.sv */
// debug port top level
`timescale 1ns/1ps

module dbp_top #(
  parameter int APB_WAIT_LIMIT = 16
) (
  input  logic              clk,
  input  logic              rst_a_s,
  input  dbp_pkg::dbg_req_t i_dbg_req,
  input  logic              i_dbg_cmdval,
  output logic              o_dbg_cmdack,
  output dbp_pkg::dbg_rsp_t o_dbg_rsp,
  output logic              o_dbg_rspval,
  input  logic              i_dbg_rspack,
  output dbp_pkg::apb_req_t o_apb,
  input  dbp_pkg::apb_rsp_t i_apb
);

  // DP configuration seen by router and ROM
  dbp_pkg::dbp_sel_t dp_select;
  logic [31:0]       dp_addr;
  logic [31:0]       rom_word;

  // start and done between router and targets
  logic              dp_start;
  logic              dp_done;
  logic              ap_start;
  logic              ap_done;
  dbp_pkg::dbg_req_t cap_req;
  dbp_pkg::dbg_rsp_t dp_rsp;
  dbp_pkg::dbg_rsp_t ap_rsp;

  dbp_cmd_router u_router (
    .clk          (clk),
    .rst_a_s      (rst_a_s),
    .i_dbg_req    (i_dbg_req),
    .i_dbg_cmdval (i_dbg_cmdval),
    .o_dbg_cmdack (o_dbg_cmdack),
    .o_dbg_rsp    (o_dbg_rsp),
    .o_dbg_rspval (o_dbg_rspval),
    .i_dbg_rspack (i_dbg_rspack),
    .i_select     (dp_select),
    .o_dp_start   (dp_start),
    .i_dp_done    (dp_done),
    .i_dp_rsp     (dp_rsp),
    .o_ap_start   (ap_start),
    .o_ap_req     (cap_req),
    .i_ap_done    (ap_done),
    .i_ap_rsp     (ap_rsp)
  );

  // captured request also feeds the register block
  dbp_dp_regs u_dp_regs (
    .clk        (clk),
    .rst_a_s    (rst_a_s),
    .i_start    (dp_start),
    .i_req      (cap_req),
    .i_rom_word (rom_word),
    .o_done     (dp_done),
    .o_rsp      (dp_rsp),
    .o_select   (dp_select),
    .o_addr     (dp_addr)
  );

  dbp_rom_table u_rom_table (
    .i_select   (dp_select),
    .i_addr     (dp_addr),
    .o_rom_word (rom_word)
  );

  dbp_apb_ap #(
    .APB_WAIT_LIMIT (APB_WAIT_LIMIT)
  ) u_apb_ap (
    .clk     (clk),
    .rst_a_s (rst_a_s),
    .i_start (ap_start),
    .i_req   (cap_req),
    .o_done  (ap_done),
    .o_rsp   (ap_rsp),
    .o_apb   (o_apb),
    .i_apb   (i_apb)
  );

endmodule

/* logic/dbp_apb_ap.sv */
// APB master access port
`timescale 1ns/1ps

module dbp_apb_ap #(
  parameter int APB_WAIT_LIMIT = 16
) (
  input  logic              clk,
  input  logic              rst_a_s,
  input  logic              i_start,
  input  dbp_pkg::dbg_req_t i_req,
  output logic              o_done,
  output dbp_pkg::dbg_rsp_t o_rsp,
  output dbp_pkg::apb_req_t o_apb,
  input  dbp_pkg::apb_rsp_t i_apb
);

  // counter wide enough for the full wait limit
  localparam int               CNT_W     = $clog2(APB_WAIT_LIMIT + 1);
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(APB_WAIT_LIMIT - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } ap_state_t;

  ap_state_t         state_q;
  logic [CNT_W-1:0]  wait_q;
  logic              done_q;

  // transfer payload
  logic [29:0]       paddr_q;
  logic              pwrite_q;
  logic              is_rd_q;
  logic [31:0]       pwdata_q;
  dbp_pkg::dbg_rsp_t rsp_q;

  logic              launch;
  logic              timeout;
  logic              finish;

  assign launch  = (state_q == ST_IDLE) && i_start;
  // last access cycle with no pready
  assign timeout = (state_q == ST_ACCESS) && !i_apb.pready && (wait_q == WAIT_LAST);
  assign finish  = (state_q == ST_ACCESS) && (i_apb.pready || timeout);

  ////////////////////////////////////////////////////////////////////////////
  // setup and access phases

  always_ff @(posedge clk or posedge rst_a_s)
  begin
    if (rst_a_s)
    begin
      state_q <= ST_IDLE;
      wait_q  <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= finish;
      case (state_q)
        ST_IDLE:
          if (i_start)
            state_q <= ST_SETUP;
        ST_SETUP:
        begin
          state_q <= ST_ACCESS;
          wait_q  <= '0;
        end
        ST_ACCESS:
          if (finish)
            state_q <= ST_IDLE;
          else
            wait_q <= wait_q + 1'b1;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // word address, direction from the command code
  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      paddr_q  <= i_req.addr[31:2];
      pwrite_q <= (i_req.cmd == dbp_pkg::CMD_WR);
      is_rd_q  <= (i_req.cmd == dbp_pkg::CMD_RD);
      pwdata_q <= i_req.wdata;
    end
    if (finish)
    begin
      rsp_q.err   <= timeout | i_apb.pslverr;
      rsp_q.rdata <= (is_rd_q && i_apb.pready) ? i_apb.prdata : '0;
    end
  end

  always_comb
  begin
    o_apb.paddr   = paddr_q;
    o_apb.psel    = (state_q != ST_IDLE);
    o_apb.penable = (state_q == ST_ACCESS);
    o_apb.pwrite  = pwrite_q;
    o_apb.pwdata  = pwdata_q;
  end

  assign o_done = done_q;
  assign o_rsp  = rsp_q;

  // a stalled slave never holds the access phase past the wait limit
  a_pen_bound: assert property (@(posedge clk) disable iff (rst_a_s)
    o_apb.penable |-> (wait_q < APB_WAIT_LIMIT));

endmodule

/* logic/dbp_cmd_router.sv */
// debug command router and response stage
`timescale 1ns/1ps

module dbp_cmd_router (
  input  logic              clk,
  input  logic              rst_a_s,
  input  dbp_pkg::dbg_req_t i_dbg_req,
  input  logic              i_dbg_cmdval,
  output logic              o_dbg_cmdack,
  output dbp_pkg::dbg_rsp_t o_dbg_rsp,
  output logic              o_dbg_rspval,
  input  logic              i_dbg_rspack,
  input  dbp_pkg::dbp_sel_t i_select,
  output logic              o_dp_start,
  input  logic              i_dp_done,
  input  dbp_pkg::dbg_rsp_t i_dp_rsp,
  output logic              o_ap_start,
  output dbp_pkg::dbg_req_t o_ap_req,
  input  logic              i_ap_done,
  input  dbp_pkg::dbg_rsp_t i_ap_rsp
);

  // control state
  logic              rdy_q;
  logic              busy_q;
  logic              rspval_q;
  logic              dp_start_q;
  logic              ap_start_q;

  // captured request and held response
  dbp_pkg::dbg_req_t req_q;
  dbp_pkg::dbg_rsp_t rsp_q;

  logic              accept;
  logic              is_sel_off;
  logic              sel_valid;
  logic              to_ap;
  logic              rsp_take;

  // no accept in the first cycle out of reset, nor while busy
  assign o_dbg_cmdack = rdy_q & ~busy_q;
  assign accept       = i_dbg_cmdval & o_dbg_cmdack;
  assign rsp_take     = rspval_q & i_dbg_rspack;

  ////////////////////////////////////////////////////////////////////////////
  // target choice

  // select offset always lands in the DP
  assign is_sel_off = (i_dbg_req.addr[dbp_pkg::DP_OFF_W-1:0] == dbp_pkg::OFF_SELECT);
  assign sel_valid  = (i_select.rsvd == '0) && (i_select.target <= dbp_pkg::SEL_APB);
  // invalid select values fall back to the DP, which errors them
  assign to_ap      = ~is_sel_off & sel_valid & (i_select.target == dbp_pkg::SEL_APB);

  always_ff @(posedge clk or posedge rst_a_s)
  begin
    if (rst_a_s)
    begin
      rdy_q      <= 1'b0;
      busy_q     <= 1'b0;
      rspval_q   <= 1'b0;
      dp_start_q <= 1'b0;
      ap_start_q <= 1'b0;
    end
    else
    begin
      rdy_q      <= 1'b1;
      dp_start_q <= accept & ~to_ap;
      ap_start_q <= accept & to_ap;
      // busy until the response handshake completes
      if (accept)
        busy_q <= 1'b1;
      else if (rsp_take)
        busy_q <= 1'b0;
      if (i_dp_done | i_ap_done)
        rspval_q <= 1'b1;
      else if (rsp_take)
        rspval_q <= 1'b0;
    end
  end

  // request held for the whole command, response until acked
  always_ff @(posedge clk)
  begin
    if (accept)
      req_q <= i_dbg_req;
    if (i_dp_done)
      rsp_q <= i_dp_rsp;
    else if (i_ap_done)
      rsp_q <= i_ap_rsp;
  end

  assign o_dp_start   = dp_start_q;
  assign o_ap_start   = ap_start_q;
  assign o_ap_req     = req_q;
  assign o_dbg_rsp    = rsp_q;
  assign o_dbg_rspval = rspval_q;

  // a target answers only the outstanding command, and only one target answers
  a_done_owned: assert property (@(posedge clk) disable iff (rst_a_s)
    (i_dp_done || i_ap_done) |-> (busy_q && !rspval_q && !(i_dp_done && i_ap_done)));

  // back-pressure keeps the response frozen
  a_rsp_hold: assert property (@(posedge clk) disable iff (rst_a_s)
    (o_dbg_rspval && !i_dbg_rspack) |=> (o_dbg_rspval && $stable(o_dbg_rsp)));

endmodule

/* logic/dbp_rom_table.sv */
// debug port ROM table
`timescale 1ns/1ps

module dbp_rom_table (
  input  dbp_pkg::dbp_sel_t i_select,
  input  logic [31:0]       i_addr,
  output logic [31:0]       o_rom_word
);

  // ROM is indexed by the low bits of the DP address register
  logic [dbp_pkg::DP_OFF_W-1:0] rom_off;
  logic                         rom_sel;
  logic [31:0]                  hit_word;

  assign rom_off = i_addr[dbp_pkg::DP_OFF_W-1:0];

  // only visible while the select target is the ROM
  assign rom_sel = (i_select.target == dbp_pkg::SEL_ROM);

  ////////////////////////////////////////////////////////////////////////////
  // entry lookup

  // scan all entries, unlisted offsets read zero
  always_comb
  begin
    hit_word = '0;
    for (int i = 0; i < dbp_pkg::ROM_ENTRIES; i++)
    begin
      if (rom_off == dbp_pkg::ROM_OFF[i])
        hit_word = dbp_pkg::ROM_VAL[i];
    end
  end

  // gated by the select target
  always_comb
  begin
    if (rom_sel)
      o_rom_word = hit_word;
    else
      o_rom_word = '0;
  end

endmodule

/* logic/dbp_dp_regs.sv */
// debug port register block
`timescale 1ns/1ps

module dbp_dp_regs (
  input  logic              clk,
  input  logic              rst_a_s,
  input  logic              i_start,
  input  dbp_pkg::dbg_req_t i_req,
  input  logic [31:0]       i_rom_word,
  output logic              o_done,
  output dbp_pkg::dbg_rsp_t o_rsp,
  output dbp_pkg::dbp_sel_t o_select,
  output logic [31:0]       o_addr
);

  // decoded offset of the captured command
  logic [dbp_pkg::DP_OFF_W-1:0] off;

  // programmer visible registers
  dbp_pkg::dbp_sel_t sel_q;
  logic [31:0]       addr_q;
  logic [31:0]       data_q;
  logic [31:0]       cmd_q;

  // select word as it would be written
  dbp_pkg::dbp_sel_t sel_wr;

  logic              is_rd;
  logic              is_wr;
  logic              is_sel_off;
  logic              rom_mode;
  logic              sel_ok;
  logic              addr_match;
  logic              addr_err;
  logic              cmd_err;
  logic              be_err;
  logic              rd_err;
  logic              tgt_err;
  logic              sel_err;
  logic              any_err;
  logic              wr_en;
  logic [31:0]       rd_word;
  dbp_pkg::dbg_rsp_t rsp_d;
  dbp_pkg::dbg_rsp_t rsp_q;
  logic              done_q;

  assign off        = i_req.addr[dbp_pkg::DP_OFF_W-1:0];
  assign sel_wr     = i_req.wdata;
  assign is_rd      = (i_req.cmd == dbp_pkg::CMD_RD);
  assign is_wr      = (i_req.cmd == dbp_pkg::CMD_WR);
  assign is_sel_off = (off == dbp_pkg::OFF_SELECT);
  assign rom_mode   = (sel_q.target == dbp_pkg::SEL_ROM);

  // DP serves non-select commands only for a clean DP or ROM target
  assign sel_ok = (sel_q.rsvd == '0) &&
                  ((sel_q.target == dbp_pkg::SEL_DP) || (sel_q.target == dbp_pkg::SEL_ROM));

  ////////////////////////////////////////////////////////////////////////////
  // offset decode and read mux

  always_comb
  begin
    addr_match = 1'b1;
    rd_word    = '0;
    case (off)
      dbp_pkg::OFF_STATUS:  rd_word = dbp_pkg::STATUS_VALUE;
      dbp_pkg::OFF_CMD:     rd_word = cmd_q;
      dbp_pkg::OFF_ADDR,
      dbp_pkg::OFF_ADDR_HI: rd_word = addr_q;
      // data reg is replaced by the ROM word in ROM mode
      dbp_pkg::OFF_DATA,
      dbp_pkg::OFF_DATA_HI: rd_word = rom_mode ? i_rom_word : data_q;
      // write only, reads flagged below
      dbp_pkg::OFF_RESET:   rd_word = '0;
      dbp_pkg::OFF_SELECT:  rd_word = sel_q;
      dbp_pkg::OFF_CSR1:    rd_word = rom_mode ? dbp_pkg::ROM_CSR1_VALUE : dbp_pkg::DP_IDENTITY;
      dbp_pkg::OFF_CSR2:    rd_word = '0;
      dbp_pkg::OFF_CSR3:    rd_word = rom_mode ? '0 : dbp_pkg::DP_IDENTITY1;
      dbp_pkg::OFF_CSR4:    rd_word = rom_mode ? '0 : dbp_pkg::DP_BASE_PTR0;
      dbp_pkg::OFF_CSR5:    rd_word = '0;
      default:              addr_match = 1'b0;
    endcase
  end

  // error sources
  assign addr_err = ~addr_match;
  assign cmd_err  = ~(is_rd | is_wr);
  assign be_err   = (i_req.be != 4'hF);
  assign rd_err   = is_rd & (off == dbp_pkg::OFF_RESET);
  assign tgt_err  = ~is_sel_off & ~sel_ok;
  // bad select value, still stored
  assign sel_err  = is_wr & is_sel_off &
                    ((sel_wr.target > dbp_pkg::SEL_APB) || (sel_wr.rsvd != '0));
  assign any_err  = addr_err | cmd_err | be_err | rd_err | tgt_err | sel_err;

  // full-word writes only
  assign wr_en = i_start & is_wr & ~be_err & ~tgt_err;

  assign rsp_d.rdata = (is_rd && !any_err) ? rd_word : '0;
  assign rsp_d.err   = any_err;

  ////////////////////////////////////////////////////////////////////////////
  // registers, written on the same edge as done

  always_ff @(posedge clk or posedge rst_a_s)
  begin
    if (rst_a_s)
    begin
      done_q <= 1'b0;
      sel_q  <= '{rsvd: '0, target: dbp_pkg::SEL_RESET};
      addr_q <= '0;
      data_q <= '0;
      cmd_q  <= '0;
    end
    else
    begin
      done_q <= i_start;
      if (wr_en)
      begin
        case (off)
          dbp_pkg::OFF_SELECT: sel_q  <= sel_wr;
          dbp_pkg::OFF_ADDR:   addr_q <= i_req.wdata;
          dbp_pkg::OFF_DATA:   data_q <= i_req.wdata;
          dbp_pkg::OFF_CMD:    cmd_q  <= i_req.wdata;
          // reset reg and read-only offsets ignore the write
          default:             ;
        endcase
      end
    end
  end

  // response word
  always_ff @(posedge clk)
  begin
    if (i_start)
      rsp_q <= rsp_d;
  end

  assign o_done   = done_q;
  assign o_rsp    = rsp_q;
  assign o_select = sel_q;
  assign o_addr   = addr_q;

  // one start per command, so done never repeats
  a_done_single: assert property (@(posedge clk) disable iff (rst_a_s)
    o_done |=> !o_done);

endmodule

/* logic/dbp_pkg.sv */
// debug port shared definitions
package dbp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // command port, select and APB types

  // one debug command word, 70 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [1:0]  cmd;
    logic [31:0] wdata;
  } dbg_req_t;

  // response, read data plus error
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } dbg_rsp_t;

  // select register, target field at the bottom
  typedef struct packed {
    logic [29:0] rsvd;
    logic [1:0]  target;
  } dbp_sel_t;

  // APB master side, word address only
  typedef struct packed {
    logic [29:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map, command codes, select targets

  localparam int DP_OFF_W = 12;

  localparam logic [DP_OFF_W-1:0] OFF_STATUS  = 12'h000;
  localparam logic [DP_OFF_W-1:0] OFF_CMD     = 12'h004;
  localparam logic [DP_OFF_W-1:0] OFF_ADDR    = 12'h008;
  localparam logic [DP_OFF_W-1:0] OFF_DATA    = 12'h00C;
  localparam logic [DP_OFF_W-1:0] OFF_RESET   = 12'h010;
  localparam logic [DP_OFF_W-1:0] OFF_DATA_HI = 12'h014;
  localparam logic [DP_OFF_W-1:0] OFF_ADDR_HI = 12'h018;
  localparam logic [DP_OFF_W-1:0] OFF_SELECT  = 12'h020;
  localparam logic [DP_OFF_W-1:0] OFF_CSR1    = 12'h400;
  localparam logic [DP_OFF_W-1:0] OFF_CSR2    = 12'h404;
  localparam logic [DP_OFF_W-1:0] OFF_CSR3    = 12'h408;
  localparam logic [DP_OFF_W-1:0] OFF_CSR4    = 12'h40C;
  localparam logic [DP_OFF_W-1:0] OFF_CSR5    = 12'h410;

  localparam logic [1:0] CMD_RD = 2'd1;
  localparam logic [1:0] CMD_WR = 2'd2;

  localparam logic [1:0] SEL_DP    = 2'd0;
  localparam logic [1:0] SEL_ROM   = 2'd1;
  localparam logic [1:0] SEL_APB   = 2'd2;
  localparam logic [1:0] SEL_RESET = 2'd0;

  // read-only words of the DP
  localparam logic [31:0] STATUS_VALUE   = 32'h0000_0024;
  localparam logic [31:0] DP_IDENTITY    = 32'h0001_04B0;
  localparam logic [31:0] DP_IDENTITY1   = 32'd32;
  localparam logic [31:0] DP_BASE_PTR0   = 32'h0000_1000;
  localparam logic [31:0] ROM_CSR1_VALUE = 32'h0000_0010;

  ////////////////////////////////////////////////////////////////////////////
  // ROM table contents, offset and word at the same index

  localparam int ROM_ENTRIES = 11;

  localparam logic [ROM_ENTRIES-1:0][DP_OFF_W-1:0] ROM_OFF = {
    12'h000, 12'h004, 12'h400, 12'hFD0, 12'hFE0, 12'hFE4,
    12'hFE8, 12'hFF0, 12'hFF4, 12'hFF8, 12'hFFC
  };

  // two component entries, CIDR1 copy, then PIDR and CIDR bytes
  localparam logic [ROM_ENTRIES-1:0][31:0] ROM_VAL = {
    32'h0000_2003, 32'h0000_3003, 32'h0000_0010, 32'h0000_0004,
    32'h0000_0001, 32'h0000_0080, 32'h0000_000D, 32'h0000_000D,
    32'h0000_0010, 32'h0000_0005, 32'h0000_00B1
  };

endpackage
